// File: source/frame_pkg.sv
// Packet stream beat type shared by the receive and transmit paths of every channel
package frame_pkg;

// Payload width of one stream beat
localparam int DATA_W = 32;

// One byte enable per data byte
localparam int KEEP_W = DATA_W / 8;

// One beat of a frame on a receive or transmit stream
// The bad flag only matters on the last beat, where it marks a frame with an error
typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [KEEP_W-1:0] keep;
    logic              last;
    logic              bad;
} frame_beat_t;

endpackage

// File: source/stat_pkg.sv
// Statistic message format, statistic kinds and counter addressing used by the stats path
package stat_pkg;

// Counter index width
localparam int STAT_ID_W = 8;

// Increment value width
localparam int STAT_INC_W = 16;

// Counters reserved per channel, the last one is unused
localparam int STAT_STRIDE = 4;

// Kinds actually counted per channel
localparam int STAT_KIND_COUNT = 3;

// Per-channel statistic kinds, value is the offset inside the channel block
typedef enum logic [1:0] {
    STAT_GOOD_FRAME = 2'd0,
    STAT_BAD_FRAME  = 2'd1,
    STAT_DROP_FRAME = 2'd2
} stat_kind_e;

// Add inc to counter id
typedef struct packed {
    logic [STAT_ID_W-1:0]  id;
    logic [STAT_INC_W-1:0] inc;
} stat_msg_t;

// Counter index of one kind on one channel
function automatic logic [STAT_ID_W-1:0] stat_index(input int ch, input stat_kind_e kind);
    return STAT_ID_W'(ch * STAT_STRIDE + int'(kind));
endfunction

endpackage

// File: source/frame_fifo.sv
// Per-channel frame FIFO, stores whole good frames and reports good, bad and dropped frames
`resetall
`timescale 1ns/10ps
`default_nettype none

module frame_fifo #(
    parameter int FIFO_DEPTH = 64,
    parameter int CH_INDEX   = 0
) (
    input  wire logic                   clk,
    input  wire logic                   rst_i,

    // Receive stream
    input  wire frame_pkg::frame_beat_t s_rx_i,
    input  wire logic                   s_rx_valid_i,
    output wire logic                   s_rx_ready_o,

    // Transmit stream
    output wire frame_pkg::frame_beat_t m_tx_o,
    output wire logic                   m_tx_valid_o,
    input  wire logic                   m_tx_ready_i,

    // Statistic increments
    output wire stat_pkg::stat_msg_t    m_stat_o,
    output wire logic                   m_stat_valid_o,
    input  wire logic                   m_stat_ready_i
);

import frame_pkg::*;
import stat_pkg::*;

localparam int ADDR_W = $clog2(FIFO_DEPTH);

frame_beat_t mem [FIFO_DEPTH];

// Extra MSB on each pointer tells full from empty
logic [ADDR_W:0] wr_ptr;
logic [ADDR_W:0] commit_ptr;
logic [ADDR_W:0] rd_ptr;
logic            drop_frame;

logic full;
logic rx_fire;
logic tx_fire;

logic [STAT_KIND_COUNT-1:0] stat_ev;
logic [STAT_INC_W-1:0]      pend_cnt [STAT_KIND_COUNT];
stat_kind_e                 pend_kind;
logic                       pend_any;
logic                       stat_load;
stat_msg_t                  stat_msg_q;
logic                       stat_valid_q;

// Input never stalls, frames that cannot be held are dropped instead
assign s_rx_ready_o = 1'b1;
assign rx_fire = s_rx_valid_i && s_rx_ready_o;

// Full against the read side, so unread beats are never overwritten
assign full = (wr_ptr == {~rd_ptr[ADDR_W], rd_ptr[ADDR_W-1:0]});

// Only committed beats are visible
assign m_tx_valid_o = (commit_ptr != rd_ptr);
assign m_tx_o = mem[rd_ptr[ADDR_W-1:0]];
assign tx_fire = m_tx_valid_o && m_tx_ready_i;

// Classify the frame on its last beat
always_comb begin
    stat_ev = '0;
    if (rx_fire && s_rx_i.last) begin
        if (drop_frame || full) begin
            stat_ev[STAT_DROP_FRAME] = 1'b1;
        end else if (s_rx_i.bad) begin
            stat_ev[STAT_BAD_FRAME] = 1'b1;
        end else begin
            stat_ev[STAT_GOOD_FRAME] = 1'b1;
        end
    end
end

// Speculative beat store
always_ff @(posedge clk) begin
    if (rx_fire && !drop_frame && !full) begin
        mem[wr_ptr[ADDR_W-1:0]] <= '{
            data: s_rx_i.data,
            keep: s_rx_i.keep,
            last: s_rx_i.last,
            bad:  1'b0
        };
    end
end

always_ff @(posedge clk) begin
    if (rst_i) begin
        wr_ptr     <= '0;
        commit_ptr <= '0;
        rd_ptr     <= '0;
        drop_frame <= 1'b0;
    end else begin
        if (tx_fire) begin
            rd_ptr <= rd_ptr + 1'b1;
        end

        if (rx_fire) begin
            if (drop_frame) begin
                // Discard the rest of an overflowing frame
                if (s_rx_i.last) begin
                    drop_frame <= 1'b0;
                end
            end else if (full) begin
                wr_ptr     <= commit_ptr;
                drop_frame <= !s_rx_i.last;
            end else if (s_rx_i.last) begin
                if (s_rx_i.bad) begin
                    // Roll back to the last good frame boundary
                    wr_ptr <= commit_ptr;
                end else begin
                    wr_ptr     <= wr_ptr + 1'b1;
                    commit_ptr <= wr_ptr + 1'b1;
                end
            end else begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end
end

// Lowest pending kind goes out first
always_comb begin
    pend_any  = 1'b0;
    pend_kind = STAT_GOOD_FRAME;
    for (int k = STAT_KIND_COUNT - 1; k >= 0; k--) begin
        if (pend_cnt[k] != '0) begin
            pend_any  = 1'b1;
            pend_kind = stat_kind_e'(k);
        end
    end
end

// Output register is free or drains this cycle
assign stat_load = !stat_valid_q || m_stat_ready_i;

always_ff @(posedge clk) begin
    if (rst_i) begin
        for (int k = 0; k < STAT_KIND_COUNT; k++) begin
            pend_cnt[k] <= '0;
        end
        stat_valid_q <= 1'b0;
    end else begin
        for (int k = 0; k < STAT_KIND_COUNT; k++) begin
            // The loaded amount moves to the message, new events keep accumulating
            if (stat_load && pend_any && pend_kind == stat_kind_e'(k)) begin
                pend_cnt[k] <= STAT_INC_W'(stat_ev[k]);
            end else begin
                pend_cnt[k] <= pend_cnt[k] + STAT_INC_W'(stat_ev[k]);
            end
        end
        if (stat_load) begin
            stat_valid_q <= pend_any;
        end
    end
end

always_ff @(posedge clk) begin
    if (stat_load && pend_any) begin
        stat_msg_q.id  <= stat_index(CH_INDEX, pend_kind);
        stat_msg_q.inc <= pend_cnt[pend_kind];
    end
end

assign m_stat_o       = stat_msg_q;
assign m_stat_valid_o = stat_valid_q;

endmodule

`resetall

// File: source/stat_arb_mux.sv
// Round-robin merge of the per-channel statistic streams into the single counter input
`resetall
`timescale 1ns/10ps
`default_nettype none

module stat_arb_mux #(
    parameter int CH_COUNT = 4
) (
    input  wire logic                clk,
    input  wire logic                rst_i,

    // Per-channel statistic inputs
    input  wire stat_pkg::stat_msg_t s_stat_i [CH_COUNT],
    input  wire logic [CH_COUNT-1:0] s_stat_valid_i,
    output wire logic [CH_COUNT-1:0] s_stat_ready_o,

    // Merged statistic output
    output wire stat_pkg::stat_msg_t m_stat_o,
    output wire logic                m_stat_valid_o,
    input  wire logic                m_stat_ready_i
);

import stat_pkg::*;

localparam int IDX_W = (CH_COUNT > 1) ? $clog2(CH_COUNT) : 1;

logic [IDX_W-1:0]    last_q;
logic [IDX_W-1:0]    grant_idx;
logic                grant_valid;
logic [CH_COUNT-1:0] grant_ready;
logic                out_ready;
logic                out_valid_q;
stat_msg_t           out_msg_q;

// Output stage empty or being drained
assign out_ready = !out_valid_q || m_stat_ready_i;

// Search starts just after the last granted input
always_comb begin
    int idx;
    grant_valid = 1'b0;
    grant_idx   = '0;
    for (int i = 1; i <= CH_COUNT; i++) begin
        idx = (int'(last_q) + i) % CH_COUNT;
        if (!grant_valid && s_stat_valid_i[idx]) begin
            grant_valid = 1'b1;
            grant_idx   = IDX_W'(idx);
        end
    end
end

// Ready only toward the winner
always_comb begin
    grant_ready = '0;
    if (out_ready && grant_valid) begin
        grant_ready[grant_idx] = 1'b1;
    end
end

assign s_stat_ready_o = grant_ready;

always_ff @(posedge clk) begin
    if (rst_i) begin
        out_valid_q <= 1'b0;
        // Input 0 wins first after reset
        last_q      <= IDX_W'(CH_COUNT - 1);
    end else if (out_ready) begin
        out_valid_q <= grant_valid;
        if (grant_valid) begin
            last_q <= grant_idx;
        end
    end
end

always_ff @(posedge clk) begin
    if (out_ready && grant_valid) begin
        out_msg_q <= s_stat_i[grant_idx];
    end
end

assign m_stat_o       = out_msg_q;
assign m_stat_valid_o = out_valid_q;

endmodule

`resetall

// File: source/stat_counters.sv
// Statistic counter array, updated by increment messages and read by the host read port
`resetall
`timescale 1ns/10ps
`default_nettype none

module stat_counters #(
    parameter int STAT_COUNT_W = 32,
    parameter int CH_COUNT     = 4
) (
    input  wire logic                           clk,
    input  wire logic                           rst_i,

    // Increment messages
    input  wire stat_pkg::stat_msg_t            s_stat_i,
    input  wire logic                           s_stat_valid_i,
    output wire logic                           s_stat_ready_o,

    // Host read request
    input  wire logic                           rd_req_valid_i,
    output wire logic                           rd_req_ready_o,
    input  wire logic [stat_pkg::STAT_ID_W-1:0] rd_addr_i,

    // Host read response
    output wire logic                           rd_resp_valid_o,
    output wire logic [STAT_COUNT_W-1:0]        rd_data_o
);

import stat_pkg::*;

localparam int CNT_N     = CH_COUNT * STAT_STRIDE;
localparam int CNT_IDX_W = $clog2(CNT_N);

logic [STAT_COUNT_W-1:0] cnt [CNT_N];

logic                    add_fire;
logic                    rd_fire;
logic [STAT_COUNT_W-1:0] add_val;
logic [STAT_COUNT_W-1:0] rd_val;
logic                    rd_resp_valid_q;
logic [STAT_COUNT_W-1:0] rd_data_q;

// In range and not the spare slot of a channel
function automatic logic id_used(input logic [STAT_ID_W-1:0] id);
    return (int'(id) < CNT_N) && ((int'(id) % STAT_STRIDE) < STAT_KIND_COUNT);
endfunction

// Both sides never stall
assign s_stat_ready_o = 1'b1;
assign rd_req_ready_o = 1'b1;

assign add_fire = s_stat_valid_i && s_stat_ready_o;
assign rd_fire  = rd_req_valid_i && rd_req_ready_o;
assign add_val  = STAT_COUNT_W'(s_stat_i.inc);

// Read value with bypass of the increment landing on the same edge
always_comb begin
    rd_val = '0;
    if (id_used(rd_addr_i)) begin
        rd_val = cnt[rd_addr_i[CNT_IDX_W-1:0]];
        if (add_fire && s_stat_i.id == rd_addr_i) begin
            rd_val = rd_val + add_val;
        end
    end
end

// Counters wrap on overflow
always_ff @(posedge clk) begin
    if (rst_i) begin
        for (int i = 0; i < CNT_N; i++) begin
            cnt[i] <= '0;
        end
    end else if (add_fire && id_used(s_stat_i.id)) begin
        cnt[s_stat_i.id[CNT_IDX_W-1:0]] <= cnt[s_stat_i.id[CNT_IDX_W-1:0]] + add_val;
    end
end

always_ff @(posedge clk) begin
    if (rst_i) begin
        rd_resp_valid_q <= 1'b0;
    end else begin
        rd_resp_valid_q <= rd_fire;
    end
end

always_ff @(posedge clk) begin
    if (rd_fire) begin
        rd_data_q <= rd_val;
    end
end

assign rd_resp_valid_o = rd_resp_valid_q;
assign rd_data_o       = rd_data_q;

endmodule

`resetall

// File: source/fpga_core.sv
// Top level of the loopback and statistics core, one frame FIFO per channel feeding the counters
`resetall
`timescale 1ns/10ps
`default_nettype none

module fpga_core #(
    parameter int CH_COUNT     = 4,
    parameter int FIFO_DEPTH   = 64,
    parameter int STAT_COUNT_W = 32
) (
    input  wire logic                           clk,
    input  wire logic                           rst_i,

    // Receive streams
    input  wire frame_pkg::frame_beat_t         s_rx_i [CH_COUNT],
    input  wire logic [CH_COUNT-1:0]            s_rx_valid_i,
    output wire logic [CH_COUNT-1:0]            s_rx_ready_o,

    // Transmit streams
    output wire frame_pkg::frame_beat_t         m_tx_o [CH_COUNT],
    output wire logic [CH_COUNT-1:0]            m_tx_valid_o,
    input  wire logic [CH_COUNT-1:0]            m_tx_ready_i,

    // Host statistics read port
    input  wire logic                           rd_req_valid_i,
    output wire logic                           rd_req_ready_o,
    input  wire logic [stat_pkg::STAT_ID_W-1:0] rd_addr_i,
    output wire logic                           rd_resp_valid_o,
    output wire logic [STAT_COUNT_W-1:0]        rd_data_o
);

import stat_pkg::*;

// Per-channel statistic streams
stat_msg_t           ch_stat [CH_COUNT];
logic [CH_COUNT-1:0] ch_stat_valid;
logic [CH_COUNT-1:0] ch_stat_ready;

// Merged statistic stream
stat_msg_t mux_stat;
logic      mux_stat_valid;
logic      mux_stat_ready;

for (genvar n = 0; n < CH_COUNT; n++) begin : ch

    frame_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH),
        .CH_INDEX(n)
    ) u_frame_fifo (
        .clk(clk),
        .rst_i(rst_i),
        .s_rx_i(s_rx_i[n]),
        .s_rx_valid_i(s_rx_valid_i[n]),
        .s_rx_ready_o(s_rx_ready_o[n]),
        .m_tx_o(m_tx_o[n]),
        .m_tx_valid_o(m_tx_valid_o[n]),
        .m_tx_ready_i(m_tx_ready_i[n]),
        .m_stat_o(ch_stat[n]),
        .m_stat_valid_o(ch_stat_valid[n]),
        .m_stat_ready_i(ch_stat_ready[n])
    );

end

stat_arb_mux #(
    .CH_COUNT(CH_COUNT)
) u_stat_arb_mux (
    .clk(clk),
    .rst_i(rst_i),
    .s_stat_i(ch_stat),
    .s_stat_valid_i(ch_stat_valid),
    .s_stat_ready_o(ch_stat_ready),
    .m_stat_o(mux_stat),
    .m_stat_valid_o(mux_stat_valid),
    .m_stat_ready_i(mux_stat_ready)
);

stat_counters #(
    .STAT_COUNT_W(STAT_COUNT_W),
    .CH_COUNT(CH_COUNT)
) u_stat_counters (
    .clk(clk),
    .rst_i(rst_i),
    .s_stat_i(mux_stat),
    .s_stat_valid_i(mux_stat_valid),
    .s_stat_ready_o(mux_stat_ready),
    .rd_req_valid_i(rd_req_valid_i),
    .rd_req_ready_o(rd_req_ready_o),
    .rd_addr_i(rd_addr_i),
    .rd_resp_valid_o(rd_resp_valid_o),
    .rd_data_o(rd_data_o)
);

endmodule

`resetall

// File: sim/fpga_core_tb.sv
// Directed testbench for the loopback and statistics core, run as the simulation top
`timescale 1ns/10ps

module fpga_core_tb;

import frame_pkg::*;
import stat_pkg::*;

localparam int CH_COUNT      = 4;
localparam int FIFO_DEPTH    = 64;
localparam int CNT_N         = CH_COUNT * STAT_STRIDE;
localparam int CLK_PERIOD_NS = 4;
localparam int RESET_CYCLES  = 8;
localparam int IDLE_CYCLES   = 3 * CH_COUNT + 6 + 2;
// Cycle budgets of reset, loopback, bad frames, overflow and concurrent tests
localparam int TEST_CYCLES   = 300 + 500 + 500 + 700 + 1000;
localparam int WATCHDOG_NS   = 2 * (RESET_CYCLES + TEST_CYCLES) * CLK_PERIOD_NS;

logic                 clk;
logic                 rst_i;
frame_beat_t          s_rx [CH_COUNT];
logic [CH_COUNT-1:0]  s_rx_valid;
logic [CH_COUNT-1:0]  s_rx_ready;
frame_beat_t          m_tx [CH_COUNT];
logic [CH_COUNT-1:0]  m_tx_valid;
logic [CH_COUNT-1:0]  tx_ready;
logic                 rd_req_valid;
logic                 rd_req_ready;
logic [STAT_ID_W-1:0] rd_addr;
logic                 rd_resp_valid;
logic [31:0]          rd_data;

// Reference model state
frame_beat_t         rx_q [CH_COUNT][$];
frame_beat_t         exp_q [CH_COUNT][$];
logic [31:0]         exp_cnt [CNT_N];
logic [CH_COUNT-1:0] tx_hold;
logic                stall_en;
logic                gap_en;
logic [15:0]         lfsr_state;

fpga_core #(
    .CH_COUNT(CH_COUNT),
    .FIFO_DEPTH(FIFO_DEPTH),
    .STAT_COUNT_W(32)
) u_fpga_core (
    .clk(clk),
    .rst_i(rst_i),
    .s_rx_i(s_rx),
    .s_rx_valid_i(s_rx_valid),
    .s_rx_ready_o(s_rx_ready),
    .m_tx_o(m_tx),
    .m_tx_valid_o(m_tx_valid),
    .m_tx_ready_i(tx_ready),
    .rd_req_valid_i(rd_req_valid),
    .rd_req_ready_o(rd_req_ready),
    .rd_addr_i(rd_addr),
    .rd_resp_valid_o(rd_resp_valid),
    .rd_data_o(rd_data)
);

initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD_NS / 2) clk = ~clk;
end

initial begin
    #(WATCHDOG_NS);
    $display("Simulation finished: FAIL");
    $fatal(1, "Timeout: the tests did not complete within the expected time");
end

task automatic check(input logic [63:0] actual, input logic [63:0] expected, input string what);
    if (actual !== expected) begin
        $display("[ERROR] %0t ns: %s: got %0h, expected %0h", $time, what, actual, expected);
        $display("Simulation finished: FAIL");
        $fatal(1, "Value mismatch");
    end
endtask

// Galois LFSR, taps 16, 14, 13, 11
function automatic logic next_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) begin
        lfsr_state = lfsr_state ^ 16'hB400;
    end
    return out;
endfunction

function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < n; i++) begin
        value = {value[30:0], next_bit()};
    end
    return value;
endfunction

// Queue one frame for sending and predict its outcome
task automatic queue_frame(input int c, input int len, input int kind);
    frame_beat_t beat;
    for (int i = 0; i < len; i++) begin
        beat.data = rand_bits(32);
        beat.last = (i == len - 1);
        beat.keep = beat.last ? KEEP_W'({KEEP_W{1'b1}} >> rand_bits(2)) : {KEEP_W{1'b1}};
        beat.bad  = beat.last && (kind == int'(STAT_BAD_FRAME));
        rx_q[c].push_back(beat);
        if (kind == int'(STAT_GOOD_FRAME)) begin
            exp_q[c].push_back(beat);
        end
    end
    exp_cnt[c * STAT_STRIDE + kind] = exp_cnt[c * STAT_STRIDE + kind] + 1;
endtask

// One clock of stimulus and transmit checking, called on a falling edge
task automatic run_cycle();
    frame_beat_t exp_beat;
    logic        rdy;
    for (int c = 0; c < CH_COUNT; c++) begin
        rdy = !tx_hold[c] && !(stall_en && rand_bits(2) == 2'b11);
        tx_ready[c] = rdy;
        if (m_tx_valid[c] && rdy) begin
            check(exp_q[c].size() != 0, 1, $sformatf("channel %0d unexpected beat", c));
            exp_beat = exp_q[c].pop_front();
            exp_beat.bad = 1'b0;
            check(m_tx[c], exp_beat, $sformatf("channel %0d transmit beat", c));
        end
        if (rx_q[c].size() != 0 && !(gap_en && next_bit())) begin
            check(s_rx_ready[c], 1'b1, $sformatf("channel %0d receive ready", c));
            s_rx[c] = rx_q[c].pop_front();
            s_rx_valid[c] = 1'b1;
        end else begin
            s_rx_valid[c] = 1'b0;
        end
    end
    @(negedge clk);
endtask

// Run until every queued beat went in and came out, then let statistics settle
task automatic drain();
    logic busy;
    busy = 1'b1;
    while (busy) begin
        run_cycle();
        busy = 1'b0;
        for (int c = 0; c < CH_COUNT; c++) begin
            if (rx_q[c].size() != 0 || exp_q[c].size() != 0) begin
                busy = 1'b1;
            end
        end
    end
    repeat (IDLE_CYCLES) run_cycle();
endtask

task automatic read_counter(input int idx, input logic [31:0] expected);
    rd_req_valid = 1'b1;
    rd_addr = STAT_ID_W'(idx);
    check(rd_req_ready, 1'b1, "read request ready");
    check(rd_resp_valid, 1'b0, "read response before request");
    @(negedge clk);
    rd_req_valid = 1'b0;
    check(rd_resp_valid, 1'b1, "read response one cycle after request");
    check(rd_data, expected, $sformatf("counter %0d", idx));
    @(negedge clk);
endtask

// Unused slot 3 of each channel is never incremented in the model
task automatic check_stats();
    for (int i = 0; i < CNT_N; i++) begin
        read_counter(i, exp_cnt[i]);
    end
    // Past the last channel, aliases counter 0 if the range is not decoded
    read_counter(CNT_N, 32'd0);
endtask

task automatic reset_state();
    check(m_tx_valid, '0, "transmit valid after reset");
    check(rd_resp_valid, 1'b0, "read response valid after reset");
    check(s_rx_ready, {CH_COUNT{1'b1}}, "receive ready after reset");
    check_stats();
endtask

task automatic good_loopback();
    for (int c = 0; c < CH_COUNT; c++) begin
        for (int f = 0; f < 5; f++) begin
            queue_frame(c, 1 + rand_bits(5) % 20, STAT_GOOD_FRAME);
        end
    end
    drain();
    check_stats();
endtask

task automatic bad_frames();
    for (int c = 0; c < CH_COUNT; c++) begin
        queue_frame(c, 6, STAT_GOOD_FRAME);
        queue_frame(c, 9, STAT_BAD_FRAME);
        queue_frame(c, 3, STAT_GOOD_FRAME);
        queue_frame(c, 1, STAT_BAD_FRAME);
        queue_frame(c, 12, STAT_GOOD_FRAME);
    end
    drain();
    check_stats();
endtask

// Channel 0 output held off, so the FIFO fills with committed frames
task automatic overflow_drop();
    int occupied;
    occupied = 0;
    tx_hold[0] = 1'b1;
    while (occupied + 20 <= FIFO_DEPTH) begin
        queue_frame(0, 20, STAT_GOOD_FRAME);
        occupied = occupied + 20;
    end
    queue_frame(0, 20, STAT_DROP_FRAME);
    while (rx_q[0].size() != 0) begin
        run_cycle();
    end
    repeat (IDLE_CYCLES) run_cycle();
    check(m_tx_valid[0], 1'b1, "committed frames held while stalled");
    tx_hold[0] = 1'b0;
    drain();
    // Longer than the whole FIFO, dropped even with the output free
    queue_frame(0, FIFO_DEPTH + 6, STAT_DROP_FRAME);
    drain();
    check_stats();
endtask

task automatic concurrent_traffic();
    int kind;
    stall_en = 1'b1;
    gap_en   = 1'b1;
    for (int f = 0; f < 8; f++) begin
        for (int c = 0; c < CH_COUNT; c++) begin
            kind = (rand_bits(2) == 0) ? int'(STAT_BAD_FRAME) : int'(STAT_GOOD_FRAME);
            queue_frame(c, 1 + rand_bits(4), kind);
        end
    end
    drain();
    stall_en = 1'b0;
    gap_en   = 1'b0;
    check_stats();
endtask

initial begin
    lfsr_state   = 16'd14;
    rst_i        = 1'b1;
    s_rx_valid   = '0;
    tx_ready     = '0;
    rd_req_valid = 1'b0;
    rd_addr      = '0;
    tx_hold      = '0;
    stall_en     = 1'b0;
    gap_en       = 1'b0;
    for (int c = 0; c < CH_COUNT; c++) begin
        s_rx[c] = '0;
    end
    for (int i = 0; i < CNT_N; i++) begin
        exp_cnt[i] = '0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_i = 1'b0;

    reset_state();
    good_loopback();
    bad_frames();
    overflow_drop();
    concurrent_traffic();

    $display("Simulation finished: PASS");
    $finish;
end

endmodule

// File: sim.f
source/frame_pkg.sv
source/stat_pkg.sv
source/frame_fifo.sv
source/stat_arb_mux.sv
source/stat_counters.sv
source/fpga_core.sv
sim/fpga_core_tb.sv
